// ==== hdl/matvec_pkg.sv ====
package matvec_pkg;

  // width of one matrix or vector element, two's complement
  localparam int elem_w = 16;

  // accumulator and result width
  // dot products wrap modulo 2^32, nothing saturates
  localparam int acc_w = 32;

  // width of one host input word
  // a configuration word carries rows in 31..16 and cols in 15..0
  // vector and matrix words only use the low elem_w bits
  localparam int word_w = 32;

  // tag that travels with every host word
  // the host sends op_cfg first, then cols op_vec words
  // and finally rows times cols op_row words in row-major order
  typedef enum logic [1:0] {
    // new dimensions, also restarts row assignment at lane 0
    op_cfg = 2'd0,
    // one element of the input vector
    op_vec = 2'd1,
    // one element of the current matrix row
    op_row = 2'd2
  } in_op_e;

endpackage

// ==== hdl/row_dispatch.sv ====
module row_dispatch #(
  parameter int NUM_LANES = 4,
  parameter int MAX_COLS  = 16,
  parameter int IN_DEPTH  = 4
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  matvec_pkg::in_op_e            in_op,
  input  logic [matvec_pkg::word_w-1:0] in_data,
  input  logic [NUM_LANES-1:0]          row_credit,
  output logic                          in_credit,
  output logic                          vec_we,
  output logic [matvec_pkg::elem_w-1:0] vec_data,
  output logic [15:0]                   cfg_cols,
  output logic [15:0]                   cfg_rows,
  output logic [NUM_LANES-1:0]          row_valid,
  output logic [matvec_pkg::elem_w-1:0] row_data
);
  import matvec_pkg::*;

  localparam int ptr_w  = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int cnt_w  = $clog2(IN_DEPTH + 1);
  localparam int lane_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int col_w  = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;

  typedef enum logic [1:0] {st_credit_init, st_run, st_stall} state_e;

  state_e               state;
  in_op_e               fifo_op   [IN_DEPTH];
  logic [word_w-1:0]    fifo_data [IN_DEPTH];
  logic [ptr_w-1:0]     wr_ptr;
  logic [ptr_w-1:0]     rd_ptr;
  logic [cnt_w-1:0]     fill;
  logic [cnt_w-1:0]     init_cnt;
  logic [NUM_LANES-1:0] lane_cred;
  logic [lane_w-1:0]    lane_ptr;
  logic [col_w-1:0]     col_cnt;
  logic [15:0]          last_col;
  in_op_e               head_op;
  logic [word_w-1:0]    head_data;
  logic                 head_ok;
  logic                 pop;
  logic                 row_done;

  assign head_op   = fifo_op[rd_ptr];
  assign head_data = fifo_data[rd_ptr];
  assign last_col  = cfg_cols - 16'd1;

  // a config word waits until every lane has drained, so the old vector
  // and the collector's row count are never disturbed mid-run
  // a row element waits for the credit of the lane it is aimed at
  always_comb begin
    case (head_op)
      op_cfg:  head_ok = &lane_cred;
      op_row:  head_ok = lane_cred[lane_ptr];
      default: head_ok = 1'b1;
    endcase
  end

  assign pop      = (state == st_run) && (fill != '0) && head_ok;
  assign row_done = pop && (head_op == op_row) && (col_cnt == last_col[col_w-1:0]);

  // the host only sends against credit, so a push always finds room
  always_ff @(posedge clk) begin
    if (in_valid) begin
      fifo_op[wr_ptr]   <= in_op;
      fifo_data[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == ptr_w'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + cnt_w'(in_valid) - cnt_w'(pop);
    end
  end

  // first IN_DEPTH cycles after reset hand out the initial credits,
  // after that every popped word gives one credit back
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= st_credit_init;
      init_cnt  <= '0;
      in_credit <= 1'b0;
    end else begin
      case (state)
        st_credit_init: begin
          in_credit <= 1'b1;
          init_cnt  <= init_cnt + 1'b1;
          if (init_cnt == cnt_w'(IN_DEPTH - 1)) begin
            state <= st_run;
          end
        end
        st_run: begin
          in_credit <= pop;
          if ((fill != '0) && !head_ok) begin
            state <= st_stall;
          end
        end
        default: begin
          // stalled on a lane, input credits stay withheld
          in_credit <= 1'b0;
          if (head_ok) begin
            state <= st_run;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_rows  <= '0;
      cfg_cols  <= '0;
      lane_ptr  <= '0;
      col_cnt   <= '0;
      lane_cred <= '1;
      vec_we    <= 1'b0;
      row_valid <= '0;
    end else begin
      vec_we    <= pop && (head_op == op_vec);
      row_valid <= '0;
      // returned credits are merged first, a finished row may clear its bit below
      lane_cred <= lane_cred | row_credit;
      if (pop) begin
        case (head_op)
          op_cfg: begin
            cfg_rows <= head_data[word_w-1 -: 16];
            cfg_cols <= head_data[15:0];
            lane_ptr <= '0;
            col_cnt  <= '0;
          end
          op_row: begin
            row_valid[lane_ptr] <= 1'b1;
            if (row_done) begin
              col_cnt             <= '0;
              lane_cred[lane_ptr] <= 1'b0;
              lane_ptr <= (lane_ptr == lane_w'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
            end else begin
              col_cnt <= col_cnt + 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // element payload for both the vector broadcast and the row path
  always_ff @(posedge clk) begin
    if (pop) begin
      vec_data <= head_data[elem_w-1:0];
      row_data <= head_data[elem_w-1:0];
    end
  end

endmodule

// ==== hdl/dot_lane.sv ====
module dot_lane #(
  parameter int MAX_COLS = 16
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          vec_we,
  input  logic [matvec_pkg::elem_w-1:0] vec_data,
  input  logic [15:0]                   cfg_cols,
  input  logic                          row_valid,
  input  logic [matvec_pkg::elem_w-1:0] row_data,
  input  logic                          res_take,
  output logic                          row_credit,
  output logic                          res_valid,
  output logic [matvec_pkg::acc_w-1:0]  res_data
);
  import matvec_pkg::*;

  localparam int col_w = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;
  // bit counter runs 0..elem_w, the last step is the accumulate
  localparam int bit_w = $clog2(elem_w + 1);

  typedef enum logic [1:0] {l_idle, l_fill, l_mul, l_hold} lane_state_e;

  lane_state_e       state;
  logic [elem_w-1:0] vec_mem [MAX_COLS];
  logic [elem_w-1:0] row_mem [MAX_COLS];
  logic [col_w-1:0]  vec_addr;
  logic [col_w-1:0]  fill_cnt;
  logic [col_w-1:0]  idx;
  logic [bit_w-1:0]  bit_cnt;
  logic [15:0]       last_col;
  logic [elem_w-1:0] mplier;
  logic              mbit;
  logic [acc_w-1:0]  mcand;
  logic [acc_w-1:0]  mcand_cur;
  logic [acc_w-1:0]  term;
  logic [acc_w-1:0]  prod;
  logic [acc_w-1:0]  acc;

  assign last_col = cfg_cols - 16'd1;

  // the row element is the multiplicand, sign extended and shifted left
  // one place per cycle, while the vector element supplies one bit per cycle
  assign mplier    = vec_mem[idx];
  assign mbit      = mplier[bit_cnt[bit_w-2:0]];
  assign mcand_cur = (bit_cnt == '0) ?
                     {{(acc_w - elem_w){row_mem[idx][elem_w-1]}}, row_mem[idx]} : mcand;
  assign term      = mbit ? mcand_cur : '0;

  assign res_valid = (state == l_hold);
  assign res_data  = acc;

  // private vector copy, the address wraps after cols writes
  always_ff @(posedge clk) begin
    if (vec_we) begin
      vec_mem[vec_addr] <= vec_data;
    end
    if (row_valid) begin
      row_mem[fill_cnt] <= row_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vec_addr <= '0;
    end else if (vec_we) begin
      vec_addr <= (vec_addr == last_col[col_w-1:0]) ? '0 : vec_addr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= l_idle;
      fill_cnt   <= '0;
      idx        <= '0;
      bit_cnt    <= '0;
      row_credit <= 1'b0;
    end else begin
      row_credit <= 1'b0;
      case (state)
        l_idle, l_fill: begin
          if (row_valid) begin
            if (fill_cnt == last_col[col_w-1:0]) begin
              fill_cnt <= '0;
              state    <= l_mul;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
              state    <= l_fill;
            end
          end
        end
        l_mul: begin
          if (bit_cnt == bit_w'(elem_w)) begin
            bit_cnt <= '0;
            if (idx == last_col[col_w-1:0]) begin
              idx   <= '0;
              state <= l_hold;
            end else begin
              idx <= idx + 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: begin
          // result handed over, the slot goes back to the dispatcher
          if (res_take) begin
            row_credit <= 1'b1;
            state      <= l_idle;
          end
        end
      endcase
    end
  end

  // sign bit of the multiplier carries negative weight, hence the subtract
  always_ff @(posedge clk) begin
    if ((state == l_idle) && row_valid) begin
      acc <= '0;
    end
    if (state == l_mul) begin
      mcand <= mcand_cur << 1;
      if (bit_cnt == bit_w'(elem_w)) begin
        acc <= acc + prod;
      end else if (bit_cnt == '0) begin
        prod <= term;
      end else if (bit_cnt == bit_w'(elem_w - 1)) begin
        prod <= prod - term;
      end else begin
        prod <= prod + term;
      end
    end
  end

endmodule

// ==== hdl/result_collect.sv ====
module result_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic [15:0]                            cfg_rows,
  input  logic [NUM_LANES-1:0]                   res_valid,
  input  logic [NUM_LANES*matvec_pkg::acc_w-1:0] res_data,
  input  logic                                   out_credit,
  output logic [NUM_LANES-1:0]                   res_take,
  output logic                                   out_valid,
  output logic [matvec_pkg::acc_w-1:0]           out_data,
  output logic                                   out_last
);
  import matvec_pkg::*;

  localparam int lane_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int cred_w = 16;

  logic [lane_w-1:0] lane_ptr;
  logic [cred_w-1:0] cred_cnt;
  logic [15:0]       row_cnt;
  logic [15:0]       rows_seen;
  logic [15:0]       last_row;
  logic              emit;

  // rows were dealt round-robin, so draining in the same order keeps row order
  assign emit      = res_valid[lane_ptr] && (cred_cnt != '0);
  assign last_row  = cfg_rows - 16'd1;
  assign out_valid = emit;
  assign out_data  = res_data[lane_ptr*acc_w +: acc_w];
  assign out_last  = emit && (row_cnt == last_row);

  always_comb begin
    res_take           = '0;
    res_take[lane_ptr] = emit;
  end

  // one slot per out_credit pulse, one slot spent per emitted result
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cred_cnt <= '0;
    end else begin
      cred_cnt <= cred_cnt + cred_w'(out_credit) - cred_w'(emit);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_ptr  <= '0;
      row_cnt   <= '0;
      rows_seen <= '0;
    end else if (cfg_rows != rows_seen) begin
      // a new configuration restarts the drain order at lane 0
      rows_seen <= cfg_rows;
      lane_ptr  <= '0;
      row_cnt   <= '0;
    end else if (emit) begin
      if (row_cnt == last_row) begin
        // end of run, the next run also starts at lane 0
        row_cnt  <= '0;
        lane_ptr <= '0;
      end else begin
        row_cnt  <= row_cnt + 16'd1;
        lane_ptr <= (lane_ptr == lane_w'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/matvec_top.sv ====
module matvec_top #(
  parameter int NUM_LANES = 4,
  parameter int MAX_COLS  = 16,
  parameter int IN_DEPTH  = 4
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  matvec_pkg::in_op_e            in_op,
  input  logic [matvec_pkg::word_w-1:0] in_data,
  output logic                          in_credit,
  input  logic                          out_credit,
  output logic                          out_valid,
  output logic [matvec_pkg::acc_w-1:0]  out_data,
  output logic                          out_last
);
  import matvec_pkg::*;

  // broadcast from the dispatcher to every lane
  logic                       vec_we;
  logic [elem_w-1:0]          vec_data;
  logic [15:0]                cfg_cols;
  logic [15:0]                cfg_rows;
  logic [elem_w-1:0]          row_data;
  // one bit per lane
  logic [NUM_LANES-1:0]       row_valid;
  logic [NUM_LANES-1:0]       row_credit;
  logic [NUM_LANES-1:0]       res_valid;
  logic [NUM_LANES-1:0]       res_take;
  // lane results packed side by side, lane 0 in the low word
  logic [NUM_LANES*acc_w-1:0] res_data;

  row_dispatch #(
    .NUM_LANES (NUM_LANES),
    .MAX_COLS  (MAX_COLS),
    .IN_DEPTH  (IN_DEPTH)
  ) i_dispatch (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_data    (in_data),
    .row_credit (row_credit),
    .in_credit  (in_credit),
    .vec_we     (vec_we),
    .vec_data   (vec_data),
    .cfg_cols   (cfg_cols),
    .cfg_rows   (cfg_rows),
    .row_valid  (row_valid),
    .row_data   (row_data)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    dot_lane #(
      .MAX_COLS (MAX_COLS)
    ) i_lane (
      .clk        (clk),
      .arst_n     (arst_n),
      .vec_we     (vec_we),
      .vec_data   (vec_data),
      .cfg_cols   (cfg_cols),
      .row_valid  (row_valid[i]),
      .row_data   (row_data),
      .res_take   (res_take[i]),
      .row_credit (row_credit[i]),
      .res_valid  (res_valid[i]),
      .res_data   (res_data[i*acc_w +: acc_w])
    );
  end

  result_collect #(
    .NUM_LANES (NUM_LANES)
  ) i_collect (
    .clk        (clk),
    .arst_n     (arst_n),
    .cfg_rows   (cfg_rows),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .out_credit (out_credit),
    .res_take   (res_take),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last)
  );

endmodule

// ==== tb/tb_matvec.sv ====
module tb_matvec;
  timeunit 1ns;
  timeprecision 100ps;
  import matvec_pkg::*;

  // mirrors of the DUT parameters
  localparam int num_lanes  = 4;
  localparam int max_cols   = 16;
  localparam int in_depth   = 4;
  localparam int clk_ns     = 4;
  // twenty random layers, then the back-pressure layer, its replay and the extreme layer
  localparam int rand_runs  = 20;
  localparam int total_runs = rand_runs + 3;
  localparam int hold_cyc   = 400;
  localparam logic [31:0] seed = 32'h2fec0422;

  logic              clk;
  logic              arst_n;
  logic              in_valid;
  in_op_e            in_op;
  logic [word_w-1:0] in_data;
  logic              in_credit;
  logic              out_credit;
  logic              out_valid;
  logic [acc_w-1:0]  out_data;
  logic              out_last;

  logic [31:0]       host_rng;
  logic [31:0]       cons_rng;
  logic [31:0]       saved_rng;
  // expected results in row order, with the out_last flag beside each one
  logic [acc_w-1:0]  exp_q [$];
  logic              last_q [$];
  int                run_rows [total_runs];
  int                run_cols [total_runs];
  int                errors;
  int                host_cred;
  int                cred_pulses;
  int                pulse_snap;
  int                results_seen;
  int                bp_base;
  int                granted;
  int                manual_credits;
  int                budget_ns;
  bit                budget_ready;
  bit                consumer_on;
  bit                hold_phase;
  bit                host_busy;

  matvec_top #(
    .NUM_LANES (num_lanes),
    .MAX_COLS  (max_cols),
    .IN_DEPTH  (in_depth)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // host side random stream, kept apart from the consumer so a layer can be replayed
  function automatic logic [31:0] draw();
    host_rng = xorshift(host_rng);
    return host_rng;
  endfunction

  // extreme mode mostly picks -32768 so the sums run past 2^31 and wrap
  function automatic logic [elem_w-1:0] pick_elem(input bit extreme);
    logic [31:0] r;
    r = draw();
    if (extreme) begin
      return (r[1:0] != 2'b00) ? 16'h8000 : 16'h7fff;
    end
    return r[elem_w-1:0];
  endfunction

  // waits for a credit, then drives one word 1 ns after the edge
  task automatic send_word(input in_op_e op, input logic [word_w-1:0] data);
    do begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end while (host_cred == 0);
    in_valid  = 1'b1;
    in_op     = op;
    in_data   = data;
    host_cred = host_cred - 1;
  endtask

  task automatic release_bus();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  // sends one layer and queues the expected wrapping dot product of every row
  task automatic run_layer(input int rows, input int cols, input bit extreme);
    logic [elem_w-1:0] vec [max_cols];
    logic [elem_w-1:0] elem;
    logic [acc_w-1:0]  acc;
    logic [acc_w-1:0]  vext;
    logic [acc_w-1:0]  rext;
    send_word(op_cfg, {rows[15:0], cols[15:0]});
    for (int c = 0; c < cols; c++) begin
      vec[c] = pick_elem(extreme);
      send_word(op_vec, {16'h0000, vec[c]});
    end
    for (int r = 0; r < rows; r++) begin
      acc = '0;
      for (int c = 0; c < cols; c++) begin
        elem = pick_elem(extreme);
        send_word(op_row, {16'h0000, elem});
        // low 32 bits of the sign-extended product equal the signed product mod 2^32
        vext = {{16{vec[c][15]}}, vec[c]};
        rext = {{16{elem[15]}}, elem};
        acc  = acc + vext * rext;
      end
      exp_q.push_back(acc);
      last_q.push_back(r == rows - 1);
    end
    release_bus();
  endtask

  task automatic check_result();
    logic [acc_w-1:0] exp_data;
    logic             exp_last;
    results_seen = results_seen + 1;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("result appeared at %0t ns with no row outstanding", $time);
    end
    if (exp_q.size() != 0) begin
      exp_data = exp_q.pop_front();
      exp_last = last_q.pop_front();
      assert (out_data == exp_data) else begin
        errors++;
        $display("mismatch out_data: got %h expected %h", out_data, exp_data);
      end
      assert (out_last == exp_last) else begin
        errors++;
        $display("mismatch out_last: got %h expected %h", out_last, exp_last);
      end
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // outputs are registered or built from registers, so mid-cycle sampling is stable
  always @(negedge clk) begin
    if (!arst_n) begin
      assert (!in_credit && !out_valid) else begin
        errors++;
        $display("in_credit or out_valid high while reset is asserted");
      end
    end else begin
      if (in_credit) begin
        cred_pulses = cred_pulses + 1;
        host_cred   = host_cred + 1;
      end
      assert (host_cred <= in_depth) else begin
        errors++;
        $display("host holds %0d credits, more than the input FIFO can take", host_cred);
      end
      if (hold_phase) begin
        assert (!out_valid) else begin
          errors++;
          $display("out_valid raised although no output credit was granted");
        end
      end
      if (out_valid) begin
        check_result();
      end
    end
  end

  // consumer never holds more credits than rows still pending, so none are left over
  initial begin
    out_credit = 1'b0;
    cons_rng   = {seed[15:0], seed[31:16]};
    forever begin
      @(posedge clk);
      #1;
      out_credit = 1'b0;
      cons_rng   = xorshift(cons_rng);
      if (manual_credits > 0) begin
        out_credit     = 1'b1;
        manual_credits = manual_credits - 1;
        granted        = granted + 1;
      end else if (consumer_on && (granted - results_seen < exp_q.size()) &&
                   (cons_rng[2:0] < 3'd3)) begin
        out_credit = 1'b1;
        granted    = granted + 1;
      end
    end
  end

  initial begin
    wait (budget_ready);
    #(budget_ns);
    errors++;
    $display("watchdog expired after %0d ns with %0d rows outstanding", budget_ns,
             exp_q.size());
    $display("errors: %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    errors         = 0;
    host_cred      = 0;
    cred_pulses    = 0;
    results_seen   = 0;
    granted        = 0;
    manual_credits = 0;
    consumer_on    = 1'b0;
    hold_phase     = 1'b0;
    host_busy      = 1'b0;
    arst_n         = 1'b0;
    in_valid       = 1'b0;
    in_op          = op_cfg;
    in_data        = '0;
    host_rng       = seed;
    for (int i = 0; i < rand_runs; i++) begin
      run_rows[i] = int'(draw() % 12) + 1;
      run_cols[i] = int'(draw() % max_cols) + 1;
    end
    // the layer for back-pressure is longer than lanes plus FIFO can absorb
    run_rows[rand_runs]     = 12;
    run_cols[rand_runs]     = 4;
    run_rows[rand_runs + 1] = 12;
    run_cols[rand_runs + 1] = 4;
    run_rows[rand_runs + 2] = 4;
    run_cols[rand_runs + 2] = max_cols;
    budget_ns = (hold_cyc + 300) * clk_ns;
    for (int i = 0; i < total_runs; i++) begin
      budget_ns += 4 * run_rows[i] * (run_cols[i] * 17 + 20) * clk_ns;
    end
    budget_ready = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // the initial grant has to arrive before the host sends anything
    repeat (in_depth + 4) @(posedge clk);
    assert (cred_pulses == in_depth) else begin
      errors++;
      $display("mismatch in_credit pulses: got %h expected %h", cred_pulses, in_depth);
    end

    // every layer brings a fresh configuration and vector
    consumer_on = 1'b1;
    for (int i = 0; i < rand_runs; i++) begin
      run_layer(run_rows[i], run_cols[i], 1'b0);
    end
    wait_drained();

    // output credits withheld, results have to pile up in the lanes
    consumer_on = 1'b0;
    saved_rng   = host_rng;
    bp_base     = results_seen;
    host_busy   = 1'b1;
    fork
      begin
        run_layer(run_rows[rand_runs], run_cols[rand_runs], 1'b0);
        host_busy = 1'b0;
      end
    join_none
    hold_phase = 1'b1;
    repeat (hold_cyc) @(posedge clk);
    pulse_snap = cred_pulses;
    repeat (50) @(posedge clk);
    hold_phase = 1'b0;
    assert (cred_pulses == pulse_snap) else begin
      errors++;
      $display("input credits kept returning while every lane was full");
    end
    assert (host_busy) else begin
      errors++;
      $display("host finished the layer although no result was taken");
    end
    // k credits release exactly k results
    @(negedge clk);
    manual_credits = num_lanes - 1;
    repeat (100) @(posedge clk);
    assert (results_seen == bp_base + num_lanes - 1) else begin
      errors++;
      $display("mismatch out_valid count: got %h expected %h", results_seen - bp_base,
               num_lanes - 1);
    end
    consumer_on = 1'b1;
    while (host_busy) begin
      @(posedge clk);
    end
    wait_drained();

    // the same layer once more with the consumer running freely
    host_rng = saved_rng;
    run_layer(run_rows[rand_runs + 1], run_cols[rand_runs + 1], 1'b0);
    wait_drained();
    run_layer(run_rows[rand_runs + 2], run_cols[rand_runs + 2], 1'b1);
    wait_drained();
    repeat (10) @(posedge clk);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/matvec_pkg.sv
hdl/row_dispatch.sv
hdl/dot_lane.sv
hdl/result_collect.sv
hdl/matvec_top.sv
tb/tb_matvec.sv

// ==== Makefile ====
TOOL      := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP       := tb_matvec
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the run is judged by the log, a missing pass line fails the target
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
